//--- hw/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN   = 32;
    localparam int HIST_W = 16;  // low half feeds T0, high half feeds T1
    localparam int TAG_W  = 10;
    localparam int PTAG_W = 6;   // upper tag bits compared on lookup

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [4:0] RA_REG    = 5'd1;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef struct packed {
        logic            is_branch;
        logic            is_jal;
        logic            is_jalr;
        logic            is_ret;
        logic [XLEN-1:0] b_imm;
        logic [XLEN-1:0] j_imm;
    } inst_class_t;

    // 2-bit saturating counter steps
    function automatic logic [1:0] ctr_inc(input logic [1:0] ctr);
        return (ctr == 2'b11) ? ctr : ctr + 2'b01;
    endfunction

    function automatic logic [1:0] ctr_dec(input logic [1:0] ctr);
        return (ctr == 2'b00) ? ctr : ctr - 2'b01;
    endfunction

endpackage

//--- hw/bpu_update_if.sv
`timescale 1ns/1ps

interface bpu_update_if;
    logic                        valid;       // one strobe per resolved transfer
    logic                        taken;
    logic                        mispredict;
    logic [bpu_pkg::XLEN-1:0]    pc;
    logic [bpu_pkg::XLEN-1:0]    target;
    logic [bpu_pkg::HIST_W-1:0]  history;     // snapshot taken at prediction
    bpu_pkg::provider_e          provider;
    logic                        is_ret;

    modport source (
        output valid, taken, mispredict, pc, target, history, provider, is_ret
    );

    modport sink (
        input valid, taken, mispredict, pc, target, history, provider, is_ret
    );
endinterface

//--- hw/branch_predecode.sv
`timescale 1ns/1ps

module branch_predecode (
    input  logic [bpu_pkg::XLEN-1:0] inst_i,
    output bpu_pkg::inst_class_t     class_o
);

    logic [6:0] opcode;
    logic [4:0] rs1;
    logic       is_jalr;

    assign opcode  = inst_i[6:0];
    assign rs1     = inst_i[19:15];
    assign is_jalr = (opcode == bpu_pkg::OP_JALR);

    // classification
    assign class_o.is_branch = (opcode == bpu_pkg::OP_BRANCH);
    assign class_o.is_jal    = (opcode == bpu_pkg::OP_JAL);
    assign class_o.is_jalr   = is_jalr;
    assign class_o.is_ret    = is_jalr && (rs1 == bpu_pkg::RA_REG);  // jalr through ra

    // B-type offset, bit 0 implied zero
    assign class_o.b_imm = {
        {(bpu_pkg::XLEN-12){inst_i[31]}},
        inst_i[7],
        inst_i[30:25],
        inst_i[11:8],
        1'b0
    };

    // J-type offset
    assign class_o.j_imm = {
        {(bpu_pkg::XLEN-20){inst_i[31]}},
        inst_i[19:12],
        inst_i[20],
        inst_i[30:21],
        1'b0
    };

endmodule

//--- hw/direction_predictor.sv
`timescale 1ns/1ps

module direction_predictor #(
    parameter int BIM_ENTRIES  = 512,
    parameter int TAGE_ENTRIES = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   pc_i,
    bpu_update_if.sink                 upd,
    output logic                       taken_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);

    localparam int HALF    = bpu_pkg::HIST_W / 2;
    localparam int T_IDX_W = $clog2(TAGE_ENTRIES);
    localparam int BIM_W   = $clog2(BIM_ENTRIES);
    localparam int TAG_W   = bpu_pkg::TAG_W;
    localparam int PTAG_W  = bpu_pkg::PTAG_W;

    logic [bpu_pkg::HIST_W-1:0] hist_q;

    logic [1:0]       bim_q  [BIM_ENTRIES];
    logic             tval_q [2][TAGE_ENTRIES];  // [0] is T0, [1] is T1
    logic [TAG_W-1:0] tag_q  [2][TAGE_ENTRIES];
    logic [1:0]       ctr_q  [2][TAGE_ENTRIES];

    logic [T_IDX_W-1:0] l_idx [2];
    logic [TAG_W-1:0]   l_tag [2];
    logic               l_hit [2];
    logic [T_IDX_W-1:0] u_idx [2];
    logic [TAG_W-1:0]   u_tag [2];
    logic [BIM_W-1:0]   l_bidx;
    logic [BIM_W-1:0]   u_bidx;
    logic               u_sel;  // which tagged table provided

    // tbl selects the history half
    function automatic logic [T_IDX_W-1:0] tage_index(input logic [bpu_pkg::XLEN-1:0] pc,
                                                      input logic [bpu_pkg::HIST_W-1:0] hist,
                                                      input int tbl);
        return pc[2 +: T_IDX_W] ^ hist[tbl*HALF +: T_IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] tage_tag(input logic [bpu_pkg::XLEN-1:0] pc,
                                                  input logic [bpu_pkg::HIST_W-1:0] hist,
                                                  input int tbl);
        if (tbl == 1)
            return pc[8 +: TAG_W] ^ TAG_W'(hist[HALF-1:0]);
        return pc[8 +: TAG_W] ^ hist[bpu_pkg::HIST_W-1 -: TAG_W];
    endfunction

    assign l_bidx    = pc_i[2 +: BIM_W];
    assign u_bidx    = upd.pc[2 +: BIM_W];
    assign u_sel     = (upd.provider == bpu_pkg::PROV_T1);
    assign history_o = hist_q;

    always_comb begin
        for (int t = 0; t < 2; t++) begin
            l_idx[t] = tage_index(pc_i, hist_q, t);
            l_tag[t] = tage_tag(pc_i, hist_q, t);
            u_idx[t] = tage_index(upd.pc, upd.history, t);
            u_tag[t] = tage_tag(upd.pc, upd.history, t);
            l_hit[t] = tval_q[t][l_idx[t]] &&
                       (tag_q[t][l_idx[t]][TAG_W-1 -: PTAG_W] == l_tag[t][TAG_W-1 -: PTAG_W]);
        end
    end

    // longest matching history wins
    always_comb begin
        if (l_hit[1]) begin
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = ctr_q[1][l_idx[1]][1];
        end else if (l_hit[0]) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = ctr_q[0][l_idx[0]][1];
        end else begin
            provider_o = bpu_pkg::PROV_BIMODAL;
            taken_o    = bim_q[l_bidx][1];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
            for (int i = 0; i < BIM_ENTRIES; i++)
                bim_q[i] <= 2'b01;  // weakly not taken
            for (int t = 0; t < 2; t++) begin
                for (int i = 0; i < TAGE_ENTRIES; i++) begin
                    tval_q[t][i] <= 1'b0;
                    tag_q[t][i]  <= '0;
                    ctr_q[t][i]  <= 2'b01;
                end
            end
        end else if (upd.valid) begin
            hist_q        <= {hist_q[bpu_pkg::HIST_W-2:0], upd.taken};
            bim_q[u_bidx] <= upd.taken ? bpu_pkg::ctr_inc(bim_q[u_bidx])
                                       : bpu_pkg::ctr_dec(bim_q[u_bidx]);
            case (upd.provider)
                bpu_pkg::PROV_T0, bpu_pkg::PROV_T1: begin
                    if (upd.mispredict)  // jump straight to strong
                        ctr_q[u_sel][u_idx[u_sel]] <= upd.taken ? 2'b11 : 2'b00;
                    else if (upd.taken)
                        ctr_q[u_sel][u_idx[u_sel]] <=
                            bpu_pkg::ctr_inc(ctr_q[u_sel][u_idx[u_sel]]);
                    else
                        ctr_q[u_sel][u_idx[u_sel]] <=
                            bpu_pkg::ctr_dec(ctr_q[u_sel][u_idx[u_sel]]);
                end
                default: begin
                    // bimodal missed, try T1 first
                    if (upd.mispredict) begin
                        if (!tval_q[1][u_idx[1]] || tag_q[1][u_idx[1]] != u_tag[1]) begin
                            tval_q[1][u_idx[1]] <= 1'b1;
                            tag_q[1][u_idx[1]]  <= u_tag[1];
                            ctr_q[1][u_idx[1]]  <= upd.taken ? 2'b10 : 2'b01;
                        end else if (!tval_q[0][u_idx[0]] ||
                                     tag_q[0][u_idx[0]] != u_tag[0]) begin
                            tval_q[0][u_idx[0]] <= 1'b1;
                            tag_q[0][u_idx[0]]  <= u_tag[0];
                            ctr_q[0][u_idx[0]]  <= upd.taken ? 2'b10 : 2'b01;
                        end
                    end
                end
            endcase
        end
    end

endmodule

//--- hw/target_predictor.sv
`timescale 1ns/1ps

module target_predictor #(
    parameter int BTB_ENTRIES = 256,
    parameter int RAS_DEPTH   = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  logic                     push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] push_addr_i,
    input  logic                     stall_i,
    bpu_update_if.sink               upd,
    output logic                     btb_hit_o,
    output logic [bpu_pkg::XLEN-1:0] btb_target_o,
    output logic                     ras_valid_o,
    output logic [bpu_pkg::XLEN-1:0] ras_top_o
);

    localparam int BTB_IDX_W = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_W = bpu_pkg::XLEN - 2 - BTB_IDX_W;
    localparam int RAS_IDX_W = $clog2(RAS_DEPTH);
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH + 1);  // must reach RAS_DEPTH

    logic                     btb_valid_q  [BTB_ENTRIES];
    logic [BTB_TAG_W-1:0]     btb_tag_q    [BTB_ENTRIES];
    logic [bpu_pkg::XLEN-1:0] btb_target_q [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] l_idx;
    logic [BTB_TAG_W-1:0] l_tag;
    logic [BTB_IDX_W-1:0] u_idx;
    logic                 btb_fill;

    logic [bpu_pkg::XLEN-1:0] ras_q [RAS_DEPTH];
    logic [RAS_PTR_W-1:0]     ras_sp;  // next free slot
    logic [RAS_IDX_W-1:0]     top_idx;
    logic [RAS_IDX_W-1:0]     wr_idx;
    logic                     push_en;
    logic                     pop_en;
    logic                     ras_full;
    logic                     wr_en;

    // BTB
    assign l_idx    = pc_i[2 +: BTB_IDX_W];
    assign l_tag    = pc_i[bpu_pkg::XLEN-1 -: BTB_TAG_W];
    assign u_idx    = upd.pc[2 +: BTB_IDX_W];
    assign btb_fill = upd.valid && upd.taken;

    assign btb_hit_o    = btb_valid_q[l_idx] && (btb_tag_q[l_idx] == l_tag);
    assign btb_target_o = btb_target_q[l_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++)
                btb_valid_q[i] <= 1'b0;
        end else if (btb_fill) begin
            btb_valid_q[u_idx] <= 1'b1;
        end
    end

    // plain overwrite on fill
    always_ff @(posedge clk) begin
        if (btb_fill) begin
            btb_tag_q[u_idx]    <= upd.pc[bpu_pkg::XLEN-1 -: BTB_TAG_W];
            btb_target_q[u_idx] <= upd.target;
        end
    end

    // return address stack
    assign push_en  = push_valid_i && !stall_i;
    assign pop_en   = upd.valid && upd.taken && upd.is_ret && (ras_sp != '0);
    assign ras_full = (ras_sp == RAS_PTR_W'(RAS_DEPTH));
    assign top_idx  = RAS_IDX_W'(ras_sp - 1'b1);

    // push and pop together replace the top
    assign wr_en  = push_en && (pop_en || !ras_full);
    assign wr_idx = pop_en ? top_idx : RAS_IDX_W'(ras_sp);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ras_sp <= '0;
        end else if (push_en && !pop_en && !ras_full) begin
            ras_sp <= ras_sp + 1'b1;
        end else if (pop_en && !push_en) begin
            ras_sp <= ras_sp - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            ras_q[wr_idx] <= push_addr_i;
    end

    assign ras_valid_o = (ras_sp != '0);
    assign ras_top_o   = ras_q[top_idx];

endmodule

//--- hw/prediction_select.sv
`timescale 1ns/1ps

module prediction_select (
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  bpu_pkg::inst_class_t     class_i,
    input  logic                     dir_taken_i,
    input  logic                     btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0] btb_target_i,
    input  logic                     ras_valid_i,
    input  logic [bpu_pkg::XLEN-1:0] ras_top_i,
    output logic                     is_ctrl_o,
    output logic                     pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0] pred_pc_o
);

    logic [bpu_pkg::XLEN-1:0] pc_plus4;

    assign pc_plus4  = pc_i + bpu_pkg::XLEN'(4);
    assign is_ctrl_o = class_i.is_branch || class_i.is_jal || class_i.is_jalr;

    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o    = pc_plus4;
        if (class_i.is_ret) begin
            pred_taken_o = 1'b1;
            if (ras_valid_i)
                pred_pc_o = ras_top_i;
            else if (btb_hit_i)
                pred_pc_o = btb_target_i;  // empty stack
        end else if (class_i.is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : pc_i + class_i.j_imm;
        end else if (class_i.is_branch) begin
            pred_taken_o = dir_taken_i;
            if (dir_taken_i)
                pred_pc_o = btb_hit_i ? btb_target_i : pc_i + class_i.b_imm;
        end else if (class_i.is_jalr) begin
            // indirect jump, only the BTB knows
            pred_taken_o = 1'b1;
            if (btb_hit_i)
                pred_pc_o = btb_target_i;
        end
    end

endmodule

//--- hw/bpu_top.sv
`timescale 1ns/1ps

module bpu_top #(
    parameter int BTB_ENTRIES  = 256,
    parameter int RAS_DEPTH    = 32,
    parameter int BIM_ENTRIES  = 512,
    parameter int TAGE_ENTRIES = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   pc_i,
    input  logic [bpu_pkg::XLEN-1:0]   inst_i,
    input  logic                       push_valid_i,
    input  logic [bpu_pkg::XLEN-1:0]   push_addr_i,
    input  logic                       stall_i,
    input  logic                       res_valid_i,
    input  logic                       res_taken_i,
    input  logic                       res_mispredict_i,
    input  logic [bpu_pkg::XLEN-1:0]   res_pc_i,
    input  logic [bpu_pkg::XLEN-1:0]   res_target_i,
    input  logic [bpu_pkg::HIST_W-1:0] res_history_i,
    input  bpu_pkg::provider_e         res_provider_i,
    input  logic                       res_is_ret_i,
    output logic                       is_ctrl_o,
    output logic                       pred_taken_o,
    output logic [bpu_pkg::XLEN-1:0]   pred_pc_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);

    bpu_update_if upd_if ();

    bpu_pkg::inst_class_t     inst_class;
    logic                     dir_taken;
    logic                     btb_hit;
    logic [bpu_pkg::XLEN-1:0] btb_target;
    logic                     ras_valid;
    logic [bpu_pkg::XLEN-1:0] ras_top;

    // resolve feedback from execute
    assign upd_if.valid      = res_valid_i;
    assign upd_if.taken      = res_taken_i;
    assign upd_if.mispredict = res_mispredict_i;
    assign upd_if.pc         = res_pc_i;
    assign upd_if.target     = res_target_i;
    assign upd_if.history    = res_history_i;
    assign upd_if.provider   = res_provider_i;
    assign upd_if.is_ret     = res_is_ret_i;

    branch_predecode u_predecode (
        .inst_i  (inst_i),
        .class_o (inst_class)
    );

    direction_predictor #(
        .BIM_ENTRIES  (BIM_ENTRIES),
        .TAGE_ENTRIES (TAGE_ENTRIES)
    ) u_direction (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (pc_i),
        .upd        (upd_if.sink),
        .taken_o    (dir_taken),
        .provider_o (provider_o),
        .history_o  (history_o)
    );

    target_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .RAS_DEPTH   (RAS_DEPTH)
    ) u_target (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc_i),
        .push_valid_i (push_valid_i),
        .push_addr_i  (push_addr_i),
        .stall_i      (stall_i),
        .upd          (upd_if.sink),
        .btb_hit_o    (btb_hit),
        .btb_target_o (btb_target),
        .ras_valid_o  (ras_valid),
        .ras_top_o    (ras_top)
    );

    prediction_select u_select (
        .pc_i         (pc_i),
        .class_i      (inst_class),
        .dir_taken_i  (dir_taken),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .ras_valid_i  (ras_valid),
        .ras_top_i    (ras_top),
        .is_ctrl_o    (is_ctrl_o),
        .pred_taken_o (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;  // release just after the edge
    end

endmodule

//--- bench/bpu_properties.sv
`timescale 1ns/1ps

module bpu_properties #(
    parameter int RAS_DEPTH = 32,
    parameter int SP_W      = $clog2(RAS_DEPTH + 1)
) (
    input logic        clk_i,
    input logic        rst_i,
    input logic [SP_W-1:0] ras_sp_i,
    input logic        upd_valid_i,
    input logic        upd_taken_i,
    input logic [15:0] hist_i
);

    a_ras_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        ras_sp_i <= SP_W'(RAS_DEPTH))
        else $error("ras pointer above depth");

    // one outcome bit per resolve
    a_hist_shift: assert property (@(posedge clk_i) disable iff (rst_i)
        upd_valid_i |=> hist_i == {$past(hist_i[14:0]), $past(upd_taken_i)})
        else $error("history did not shift by one bit");

    a_hist_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        !upd_valid_i |=> $stable(hist_i))
        else $error("history changed without a resolve");

endmodule

bind target_predictor bpu_properties #(.RAS_DEPTH(RAS_DEPTH)) u_ras_props (
    .clk_i(clk), .rst_i(rst), .ras_sp_i(ras_sp), .upd_valid_i(1'b0), .upd_taken_i(1'b0),
    .hist_i(16'd0)
);

bind direction_predictor bpu_properties u_hist_props (
    .clk_i(clk), .rst_i(rst), .ras_sp_i('0), .upd_valid_i(upd.valid),
    .upd_taken_i(upd.taken), .hist_i(hist_q)
);

//--- bench/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb;

    localparam int BTB_ENTRIES  = 256;
    localparam int RAS_DEPTH    = 32;
    localparam int BIM_ENTRIES  = 512;
    localparam int TAGE_ENTRIES = 256;
    localparam int N_RANDOM     = 3000;
    localparam int TEST_CYCLES  = N_RANDOM + 100;
    localparam logic [31:0] NOP = 32'h00000013;
    localparam logic [31:0] RET = 32'h00008067;  // jalr x0, 0(x1)

    logic        clk, rst;
    logic [31:0] pc, inst, push_addr, res_pc, res_target;
    logic        push_valid, stall, res_valid, res_taken, res_mispredict, res_is_ret;
    logic [15:0] res_history;
    bpu_pkg::provider_e res_provider;
    logic        is_ctrl, pred_taken;
    logic [31:0] pred_pc;
    bpu_pkg::provider_e provider;
    logic [15:0] history;

    // shadow model of every table
    logic [15:0] m_hist;
    logic [1:0]  m_bim  [BIM_ENTRIES];
    logic        m_tval [2][TAGE_ENTRIES];
    logic [9:0]  m_tag  [2][TAGE_ENTRIES];
    logic [1:0]  m_ctr  [2][TAGE_ENTRIES];
    logic        m_bval [BTB_ENTRIES];
    logic [21:0] m_btag [BTB_ENTRIES];
    logic [31:0] m_btgt [BTB_ENTRIES];
    logic [31:0] m_ras  [RAS_DEPTH];
    int          m_sp;

    int          errors;
    int          checks;
    logic [31:0] lfsr;
    logic        e_ctrl, e_taken;
    logic [31:0] e_pc;
    bpu_pkg::provider_e e_prov;
    logic [31:0] stack_addr [3];

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    bpu_top #(
        .BTB_ENTRIES(BTB_ENTRIES), .RAS_DEPTH(RAS_DEPTH),
        .BIM_ENTRIES(BIM_ENTRIES), .TAGE_ENTRIES(TAGE_ENTRIES)
    ) dut (
        .clk(clk), .rst(rst), .pc_i(pc), .inst_i(inst),
        .push_valid_i(push_valid), .push_addr_i(push_addr), .stall_i(stall),
        .res_valid_i(res_valid), .res_taken_i(res_taken), .res_mispredict_i(res_mispredict),
        .res_pc_i(res_pc), .res_target_i(res_target), .res_history_i(res_history),
        .res_provider_i(res_provider), .res_is_ret_i(res_is_ret),
        .is_ctrl_o(is_ctrl), .pred_taken_o(pred_taken), .pred_pc_o(pred_pc),
        .provider_o(provider), .history_o(history)
    );

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [12:0] sx13(input logic [5:0] v);
        return {{6{v[5]}}, v, 1'b0};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], bpu_pkg::OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, bpu_pkg::OP_JAL};
    endfunction

    function automatic logic [7:0] t_index(input logic [31:0] p, input logic [15:0] h,
                                           input int t);
        return p[9:2] ^ ((t == 1) ? h[15:8] : h[7:0]);
    endfunction

    // T1 folds the short half into its tag and T0 the top ten bits
    function automatic logic [9:0] t_tag(input logic [31:0] p, input logic [15:0] h,
                                         input int t);
        return (t == 1) ? (p[17:8] ^ {2'b00, h[7:0]}) : (p[17:8] ^ h[15:6]);
    endfunction

    function automatic logic [1:0] sat_step(input logic [1:0] c, input logic up);
        if (up)
            return (c == 2'd3) ? c : c + 2'd1;
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic void dir_lookup(input logic [31:0] p, input logic [15:0] h,
                                       output logic tk, output bpu_pkg::provider_e pv);
        logic [7:0] i0, i1;
        logic [9:0] g0, g1;
        i0 = t_index(p, h, 0);
        i1 = t_index(p, h, 1);
        g0 = t_tag(p, h, 0);
        g1 = t_tag(p, h, 1);
        if (m_tval[1][i1] && m_tag[1][i1][9:4] == g1[9:4]) begin
            pv = bpu_pkg::PROV_T1;
            tk = m_ctr[1][i1][1];
        end else if (m_tval[0][i0] && m_tag[0][i0][9:4] == g0[9:4]) begin
            pv = bpu_pkg::PROV_T0;
            tk = m_ctr[0][i0][1];
        end else begin
            pv = bpu_pkg::PROV_BIMODAL;
            tk = m_bim[p[10:2]][1];
        end
    endfunction

    // expected prediction from the shadow model
    function automatic void ref_predict(input logic [31:0] p, input logic [31:0] ins,
                                        output logic ctrl, output logic tk,
                                        output logic [31:0] npc,
                                        output bpu_pkg::provider_e pv);
        logic [6:0]  op;
        logic [31:0] bimm, jimm;
        logic [7:0]  bi;
        logic        hit, dtk;
        op   = ins[6:0];
        bimm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        jimm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        bi   = p[9:2];
        hit  = m_bval[bi] && m_btag[bi] == p[31:10];
        dir_lookup(p, m_hist, dtk, pv);
        ctrl = op == bpu_pkg::OP_BRANCH || op == bpu_pkg::OP_JAL || op == bpu_pkg::OP_JALR;
        tk   = 1'b0;
        npc  = p + 32'd4;
        if (op == bpu_pkg::OP_JALR && ins[19:15] == 5'd1) begin
            tk = 1'b1;
            if (m_sp > 0)
                npc = m_ras[m_sp-1];
            else if (hit)
                npc = m_btgt[bi];
        end else if (op == bpu_pkg::OP_JAL) begin
            tk  = 1'b1;
            npc = hit ? m_btgt[bi] : p + jimm;
        end else if (op == bpu_pkg::OP_BRANCH) begin
            tk = dtk;
            if (dtk)
                npc = hit ? m_btgt[bi] : p + bimm;
        end else if (op == bpu_pkg::OP_JALR) begin
            tk = 1'b1;
            if (hit)
                npc = m_btgt[bi];
        end
    endfunction

    task automatic model_reset();
        m_hist = '0;
        m_sp   = 0;
        foreach (m_bim[i]) m_bim[i] = 2'b01;
        foreach (m_bval[i]) m_bval[i] = 1'b0;
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < TAGE_ENTRIES; i++) begin
                m_tval[t][i] = 1'b0;
                m_tag[t][i]  = '0;
                m_ctr[t][i]  = 2'b01;
            end
        end
    endtask

    task automatic model_step();
        logic [7:0] ui [2];
        logic [9:0] ug [2];
        int         s;
        logic       push_en, pop_en;
        push_en = push_valid && !stall;
        pop_en  = res_valid && res_taken && res_is_ret && m_sp > 0;
        if (res_valid) begin
            for (int t = 0; t < 2; t++) begin
                ui[t] = t_index(res_pc, res_history, t);
                ug[t] = t_tag(res_pc, res_history, t);
            end
            m_bim[res_pc[10:2]] = sat_step(m_bim[res_pc[10:2]], res_taken);
            if (res_provider != bpu_pkg::PROV_BIMODAL) begin
                s = (res_provider == bpu_pkg::PROV_T1) ? 1 : 0;
                if (res_mispredict)
                    m_ctr[s][ui[s]] = res_taken ? 2'b11 : 2'b00;
                else
                    m_ctr[s][ui[s]] = sat_step(m_ctr[s][ui[s]], res_taken);
            end else if (res_mispredict) begin
                s = -1;
                if (!m_tval[1][ui[1]] || m_tag[1][ui[1]] != ug[1])
                    s = 1;
                else if (!m_tval[0][ui[0]] || m_tag[0][ui[0]] != ug[0])
                    s = 0;
                if (s >= 0) begin
                    m_tval[s][ui[s]] = 1'b1;
                    m_tag[s][ui[s]]  = ug[s];
                    m_ctr[s][ui[s]]  = res_taken ? 2'b10 : 2'b01;
                end
            end
            m_hist = {m_hist[14:0], res_taken};
            if (res_taken) begin
                m_bval[res_pc[9:2]] = 1'b1;
                m_btag[res_pc[9:2]] = res_pc[31:10];
                m_btgt[res_pc[9:2]] = res_target;
            end
        end
        if (push_en && pop_en) begin
            m_ras[m_sp-1] = push_addr;
        end else if (push_en && m_sp < RAS_DEPTH) begin
            m_ras[m_sp] = push_addr;
            m_sp++;
        end else if (pop_en) begin
            m_sp--;
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst)
            model_reset();
        else
            model_step();
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // compare every cycle where outputs are settled
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            ref_predict(pc, inst, e_ctrl, e_taken, e_pc, e_prov);
            check_val("is_ctrl_o", 32'(is_ctrl), 32'(e_ctrl));
            check_val("pred_taken_o", 32'(pred_taken), 32'(e_taken));
            check_val("pred_pc_o", pred_pc, e_pc);
            check_val("provider_o", 32'(provider), 32'(e_prov));
            check_val("history_o", 32'(history), 32'(m_hist));
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        res_valid  = 1'b0;
        res_is_ret = 1'b0;
        push_valid = 1'b0;
        stall      = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] p, input logic [31:0] ins);
        pc   = p;
        inst = ins;
    endtask

    // provider and mispredict as the model would have predicted with h
    task automatic resolve(input logic [31:0] rpc, input logic tk, input logic [31:0] tgt,
                           input logic ret, input logic [15:0] h);
        logic               ptk;
        bpu_pkg::provider_e pv;
        dir_lookup(rpc, h, ptk, pv);
        res_valid      = 1'b1;
        res_pc         = rpc;
        res_taken      = tk;
        res_target     = tgt;
        res_is_ret     = ret;
        res_history    = h;
        res_provider   = pv;
        res_mispredict = (ptk != tk);
    endtask

    task automatic random_cycle();
        logic [31:0] r, p, ins;
        r   = rand_bits(6);
        p   = 32'h1000 + {24'd0, r[5:0], 2'b00};
        r   = rand_bits(3);
        ins = NOP;
        case (r[2:0])
            3'd2, 3'd3, 3'd4: begin
                r   = rand_bits(6);
                ins = enc_branch(sx13(r[5:0]));
            end
            3'd5: begin
                r   = rand_bits(6);
                ins = enc_jal({{8{r[5]}}, sx13(r[5:0])});
            end
            3'd6: ins = RET;
            3'd7: ins = {12'd0, 5'd5, 3'b000, 5'd1, bpu_pkg::OP_JALR};
            default: ins = NOP;
        endcase
        fetch(p, ins);
        r = rand_bits(1);
        if (r[0]) begin
            r = rand_bits(6);
            p = 32'h1000 + {24'd0, r[5:0], 2'b00};
            r = rand_bits(4);
            resolve(p, r[0], 32'h2000 + {22'd0, r[3:1], 7'd0}, r[3:2] == 2'b00, m_hist);
        end
        r = rand_bits(2);
        if (r[1:0] == 2'b00) begin
            push_valid = 1'b1;
            r          = rand_bits(10);
            push_addr  = 32'h3000 + {20'd0, r[9:0], 2'b00};
            r          = rand_bits(2);
            stall      = (r[1:0] == 2'b00);
        end
    endtask

    initial begin
        #((TEST_CYCLES + 10) * 40 + 2000);
        $display("watchdog expired before the tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        errors = 0;
        checks = 0;
        lfsr   = 32'ha0b8b334;
        pc             = '0;
        inst           = NOP;
        push_valid     = 1'b0;
        push_addr      = '0;
        stall          = 1'b0;
        res_valid      = 1'b0;
        res_taken      = 1'b0;
        res_mispredict = 1'b0;
        res_pc         = '0;
        res_target     = '0;
        res_history    = '0;
        res_provider   = bpu_pkg::PROV_BIMODAL;
        res_is_ret     = 1'b0;
        stack_addr = '{32'h0000c000, 32'h0000b000, 32'h0000a000};
        @(negedge rst);
        next_cycle();

        // plain instruction and then a cold branch
        fetch(32'h100, NOP);
        next_cycle();
        fetch(32'h200, enc_branch(13'h040));
        next_cycle();

        // jal decoded and then redirected by the BTB
        fetch(32'h300, enc_jal(21'h800));
        @(negedge clk);
        check_val("pred_pc_o", pred_pc, 32'h00000b00);
        next_cycle();
        resolve(32'h300, 1'b1, 32'h5000, 1'b0, m_hist);
        fetch(32'h100, NOP);
        next_cycle();
        fetch(32'h300, enc_jal(21'h800));
        @(negedge clk);
        check_val("pred_pc_o", pred_pc, 32'h00005000);
        next_cycle();

        // bimodal trained to taken
        repeat (2) begin
            resolve(32'h400, 1'b1, 32'h420, 1'b0, m_hist);
            fetch(32'h100, NOP);
            next_cycle();
        end
        fetch(32'h400, enc_branch(13'h020));
        @(negedge clk);
        check_val("pred_taken_o", 32'(pred_taken), 32'd1);
        check_val("pred_pc_o", pred_pc, 32'h00000420);
        next_cycle();

        // allocate T1 under the history that the next lookup will see
        resolve(32'h600, 1'b1, 32'h680, 1'b0, {m_hist[14:0], 1'b1});
        next_cycle();
        fetch(32'h600, enc_branch(13'h080));
        @(negedge clk);
        check_val("provider_o", 32'(provider), 32'(bpu_pkg::PROV_T1));
        next_cycle();

        // RAS order with a stalled push dropped
        for (int k = 2; k >= 0; k--) begin
            push_valid = 1'b1;
            push_addr  = stack_addr[k];
            next_cycle();
        end
        push_valid = 1'b1;
        stall      = 1'b1;
        push_addr  = 32'h000dead0;
        next_cycle();
        for (int k = 0; k < 3; k++) begin
            fetch(32'h700, RET);
            resolve(32'h700, 1'b1, stack_addr[k], 1'b1, m_hist);
            @(negedge clk);
            check_val("pred_pc_o", pred_pc, stack_addr[k]);
            next_cycle();
        end
        fetch(32'h700, RET);  // empty stack falls back to the BTB
        next_cycle();

        repeat (N_RANDOM) begin
            random_cycle();
            next_cycle();
        end
        @(negedge clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- sim.f
hw/bpu_pkg.sv
hw/bpu_update_if.sv
hw/branch_predecode.sv
hw/direction_predictor.sv
hw/target_predictor.sv
hw/prediction_select.sv
hw/bpu_top.sv
bench/tb_clock.sv
bench/bpu_properties.sv
bench/bpu_tb.sv

//--- Makefile
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: obj_dir/Vbpu_tb

obj_dir/Vbpu_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module bpu_tb -o Vbpu_tb

run: obj_dir/Vbpu_tb
	./obj_dir/Vbpu_tb | tee /dev/stderr | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
